// File: Makefile
# Verilator build for the execute core testbench

OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 \
		--top-module tb_exec_core -f project.f \
		-Mdir $(OBJ_DIR) -o sim_exec_core

run: compile
	./$(OBJ_DIR)/sim_exec_core | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/alu.sv
`default_nettype none

module alu (
  input  core_pkg::issue_t iss,
  output logic [31:0]      alu_result,
  output logic             alu_overflow
);

  logic [31:0] a;
  logic [31:0] b;
  logic [4:0]  shamt;
  logic [31:0] sum;
  logic [31:0] diff;
  logic [63:0] rot;
  logic        add_ovf;
  logic        sub_ovf;

  assign a     = iss.operand_a;
  assign b     = iss.operand_b;
  assign shamt = b[4:0];

  assign sum  = a + b;
  assign diff = a - b;
  assign rot  = {a, a} >> shamt;

  // signed overflow from the operand and result sign bits
  assign add_ovf = (a[31] == b[31]) && (sum[31] != a[31]);
  assign sub_ovf = (a[31] != b[31]) && (diff[31] != a[31]);

  always_comb begin
    alu_result   = '0;
    alu_overflow = 1'b0;
    case (iss.alu_op)
      // alu_1 add never flags overflow
      core_pkg::alu_add: alu_result = sum;
      core_pkg::alu_add_ov: begin
        alu_result   = sum;
        alu_overflow = add_ovf;
      end
      core_pkg::alu_sub: begin
        alu_result   = diff;
        alu_overflow = sub_ovf;
      end
      core_pkg::alu_and:    alu_result = a & b;
      core_pkg::alu_or:     alu_result = a | b;
      core_pkg::alu_xor:    alu_result = a ^ b;
      core_pkg::alu_srl:    alu_result = a >> shamt;
      core_pkg::alu_sll:    alu_result = a << shamt;
      core_pkg::alu_rotr:   alu_result = rot[31:0];
      core_pkg::alu_pass_b: alu_result = b;
      default:              alu_result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/core_pkg.sv
`default_nettype none

package core_pkg;

  // major opcodes
  localparam logic [5:0] op_alu_1 = 6'b100000;
  localparam logic [5:0] op_addi  = 6'b101000;
  localparam logic [5:0] op_ori   = 6'b101100;
  localparam logic [5:0] op_xori  = 6'b101011;
  localparam logic [5:0] op_movi  = 6'b100010;

  // alu_1 sub-opcodes, srli by zero doubles as nop
  localparam logic [4:0] sub_add   = 5'b00000;
  localparam logic [4:0] sub_sub   = 5'b00001;
  localparam logic [4:0] sub_and   = 5'b00010;
  localparam logic [4:0] sub_or    = 5'b00100;
  localparam logic [4:0] sub_xor   = 5'b00011;
  localparam logic [4:0] sub_srli  = 5'b01001;
  localparam logic [4:0] sub_slli  = 5'b01000;
  localparam logic [4:0] sub_rotri = 5'b01011;

  typedef struct packed {
    logic       top;
    logic [5:0] opcode;
    logic [4:0] rt;
    logic [4:0] ra;
    logic [4:0] rb;
    logic [4:0] spare;
    logic [4:0] sub_opcode;
  } r_form_t;

  typedef struct packed {
    logic        top;
    logic [5:0]  opcode;
    logic [4:0]  rt;
    logic [4:0]  ra;
    logic [14:0] imm;
  } i_form_t;

  typedef struct packed {
    logic        top;
    logic [5:0]  opcode;
    logic [4:0]  rt;
    logic [19:0] imm;
  } movi_form_t;

  typedef union packed {
    r_form_t    r_form;
    i_form_t    i_form;
    movi_form_t movi_form;
  } insn_u;

  // add_ov is the addi flavour that reports overflow
  typedef enum logic [3:0] {
    alu_add,
    alu_add_ov,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_srl,
    alu_sll,
    alu_rotr,
    alu_pass_b
  } alu_op_e;

  typedef struct packed {
    alu_op_e     alu_op;
    logic [4:0]  rt;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic        use_imm;
    logic [31:0] imm;
    logic        writes;
    logic        illegal;
  } decode_t;

  typedef struct packed {
    logic        valid;
    alu_op_e     alu_op;
    logic [4:0]  rt;
    logic        writes;
    logic        illegal;
    logic [31:0] operand_a;
    logic [31:0] operand_b;
  } issue_t;

  typedef struct packed {
    logic        valid;
    logic        illegal;
    logic [4:0]  rd;
    logic [31:0] data;
    logic        overflow;
  } retire_t;

endpackage

`default_nettype wire

// File: design/exec_core.sv
`default_nettype none

module exec_core #(
  parameter int reg_count = 32
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              insn_valid,
  input  core_pkg::insn_u   insn,
  output core_pkg::retire_t retire
);

  core_pkg::decode_t dec;
  core_pkg::issue_t  iss;
  logic [4:0]        rd_addr_a;
  logic [4:0]        rd_addr_b;
  logic [31:0]       rd_data_a;
  logic [31:0]       rd_data_b;
  logic [31:0]       alu_result;
  logic              alu_overflow;
  logic              wr_en;
  logic [4:0]        wr_addr;
  logic [31:0]       wr_data;

  insn_decoder #(.reg_count(reg_count)) u_decoder (
    .insn (insn),
    .dec  (dec)
  );

  reg_file #(.reg_count(reg_count)) u_reg_file (
    .clk       (clk),
    .reset     (reset),
    .rd_addr_a (rd_addr_a),
    .rd_addr_b (rd_addr_b),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b)
  );

  issue_stage #(.reg_count(reg_count)) u_issue (
    .clk        (clk),
    .reset      (reset),
    .insn_valid (insn_valid),
    .dec        (dec),
    .rd_data_a  (rd_data_a),
    .rd_data_b  (rd_data_b),
    .fwd_result (alu_result),
    .rd_addr_a  (rd_addr_a),
    .rd_addr_b  (rd_addr_b),
    .iss        (iss)
  );

  alu u_alu (
    .iss          (iss),
    .alu_result   (alu_result),
    .alu_overflow (alu_overflow)
  );

  writeback_stage u_writeback (
    .clk          (clk),
    .reset        (reset),
    .iss          (iss),
    .alu_result   (alu_result),
    .alu_overflow (alu_overflow),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .retire       (retire)
  );

endmodule

`default_nettype wire

// File: design/insn_decoder.sv
`default_nettype none

module insn_decoder #(
  parameter int reg_count = 32
) (
  input  core_pkg::insn_u   insn,
  output core_pkg::decode_t dec
);

  function automatic logic in_range(input logic [4:0] idx);
    return 32'(idx) < reg_count;
  endfunction

  always_comb begin
    logic bad_code;
    logic bad_reg;

    bad_code = 1'b0;
    dec = '0;
    dec.alu_op = core_pkg::alu_pass_b;
    dec.writes = 1'b1;

    case (insn.r_form.opcode)
      core_pkg::op_alu_1: begin
        dec.rt = insn.r_form.rt;
        dec.ra = insn.r_form.ra;
        dec.rb = insn.r_form.rb;
        case (insn.r_form.sub_opcode)
          core_pkg::sub_add: dec.alu_op = core_pkg::alu_add;
          core_pkg::sub_sub: dec.alu_op = core_pkg::alu_sub;
          core_pkg::sub_and: dec.alu_op = core_pkg::alu_and;
          core_pkg::sub_or:  dec.alu_op = core_pkg::alu_or;
          core_pkg::sub_xor: dec.alu_op = core_pkg::alu_xor;
          core_pkg::sub_srli, core_pkg::sub_slli, core_pkg::sub_rotri: begin
            // shift amount is the rb field itself, no register read
            dec.use_imm = 1'b1;
            dec.imm = {27'b0, insn.r_form.rb};
            dec.rb = '0;
            if (insn.r_form.sub_opcode == core_pkg::sub_srli) begin
              dec.alu_op = core_pkg::alu_srl;
              // srli by zero is the nop
              dec.writes = (insn.r_form.rb != 5'd0);
            end else if (insn.r_form.sub_opcode == core_pkg::sub_slli) begin
              dec.alu_op = core_pkg::alu_sll;
            end else begin
              dec.alu_op = core_pkg::alu_rotr;
            end
          end
          default: bad_code = 1'b1;
        endcase
      end
      core_pkg::op_addi: begin
        dec.alu_op = core_pkg::alu_add_ov;
        dec.rt = insn.i_form.rt;
        dec.ra = insn.i_form.ra;
        dec.use_imm = 1'b1;
        dec.imm = {{17{insn.i_form.imm[14]}}, insn.i_form.imm};
      end
      core_pkg::op_ori, core_pkg::op_xori: begin
        dec.alu_op = (insn.i_form.opcode == core_pkg::op_ori) ?
                     core_pkg::alu_or : core_pkg::alu_xor;
        dec.rt = insn.i_form.rt;
        dec.ra = insn.i_form.ra;
        dec.use_imm = 1'b1;
        dec.imm = {17'b0, insn.i_form.imm};
      end
      core_pkg::op_movi: begin
        dec.rt = insn.movi_form.rt;
        dec.use_imm = 1'b1;
        dec.imm = {{12{insn.movi_form.imm[19]}}, insn.movi_form.imm};
      end
      default: bad_code = 1'b1;
    endcase

    // unused index fields stay zero, so every field can be checked
    bad_reg = !in_range(dec.rt) || !in_range(dec.ra) || !in_range(dec.rb);

    dec.illegal = bad_code || bad_reg;
    if (dec.illegal) begin
      dec.writes = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: design/issue_stage.sv
`default_nettype none

module issue_stage #(
  parameter int reg_count = 32
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              insn_valid,
  input  core_pkg::decode_t dec,
  input  logic [31:0]       rd_data_a,
  input  logic [31:0]       rd_data_b,
  input  logic [31:0]       fwd_result,
  output logic [4:0]        rd_addr_a,
  output logic [4:0]        rd_addr_b,
  output core_pkg::issue_t  iss
);

  logic             fwd_a;
  logic             fwd_b;
  logic [31:0]      val_a;
  logic [31:0]      val_b;
  core_pkg::issue_t iss_next;

  // illegal indices read register 0, the value is never used
  assign rd_addr_a = (32'(dec.ra) < reg_count) ? dec.ra : 5'd0;
  assign rd_addr_b = (32'(dec.rb) < reg_count) ? dec.rb : 5'd0;

  // instruction now in the alu writes its result at this same edge
  assign fwd_a = iss.valid && iss.writes && (iss.rt == dec.ra);
  assign fwd_b = iss.valid && iss.writes && (iss.rt == dec.rb);

  assign val_a = fwd_a ? fwd_result : rd_data_a;
  assign val_b = fwd_b ? fwd_result : rd_data_b;

  always_comb begin
    iss_next.valid     = insn_valid;
    iss_next.alu_op    = dec.alu_op;
    iss_next.rt        = dec.rt;
    iss_next.writes    = dec.writes;
    iss_next.illegal   = dec.illegal;
    iss_next.operand_a = val_a;
    iss_next.operand_b = dec.use_imm ? dec.imm : val_b;
  end

  always_ff @(posedge clk) begin
    iss <= iss_next;
    if (reset) begin
      iss.valid <= 1'b0;
    end
  end

  // valid feeds both the forward compare and the file write
  iss_valid_known: assert property (
    @(posedge clk) disable iff (reset)
    !$isunknown(iss.valid)
  ) else $error("issue valid is unknown");

endmodule

`default_nettype wire

// File: design/reg_file.sv
`default_nettype none

module reg_file #(
  parameter int reg_count = 32
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [4:0]  rd_addr_a,
  input  logic [4:0]  rd_addr_b,
  input  logic        wr_en,
  input  logic [4:0]  wr_addr,
  input  logic [31:0] wr_data,
  output logic [31:0] rd_data_a,
  output logic [31:0] rd_data_b
);

  localparam int idx_w = $clog2(reg_count);

  logic [31:0] regs [reg_count];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_addr[idx_w-1:0]] <= wr_data;
    end
  end

  // read addresses arrive already clamped into range
  assign rd_data_a = regs[rd_addr_a[idx_w-1:0]];
  assign rd_data_b = regs[rd_addr_b[idx_w-1:0]];

  // decoder must have rejected out-of-range destinations
  wr_addr_in_range: assert property (
    @(posedge clk) disable iff (reset)
    wr_en |-> (32'(wr_addr) < reg_count)
  ) else $error("write to register %0d beyond file size", wr_addr);

endmodule

`default_nettype wire

// File: design/writeback_stage.sv
`default_nettype none

module writeback_stage (
  input  logic              clk,
  input  logic              reset,
  input  core_pkg::issue_t  iss,
  input  logic [31:0]       alu_result,
  input  logic              alu_overflow,
  output logic              wr_en,
  output logic [4:0]        wr_addr,
  output logic [31:0]       wr_data,
  output core_pkg::retire_t retire
);

  core_pkg::retire_t retire_next;

  assign wr_en   = iss.valid && iss.writes && !iss.illegal;
  assign wr_addr = iss.rt;
  assign wr_data = alu_result;

  // nops and illegal ops report zero data and no overflow
  always_comb begin
    retire_next.valid    = iss.valid;
    retire_next.illegal  = iss.illegal;
    retire_next.rd       = iss.rt;
    retire_next.data     = wr_en ? alu_result : 32'd0;
    retire_next.overflow = wr_en && alu_overflow;
  end

  always_ff @(posedge clk) begin
    retire <= retire_next;
    if (reset) begin
      retire.valid   <= 1'b0;
      retire.illegal <= 1'b0;
    end
  end

  // decoder clears writes for every illegal word
  illegal_never_writes: assert property (
    @(posedge clk) disable iff (reset)
    (iss.valid && iss.illegal) |-> !iss.writes
  ) else $error("illegal instruction arrived marked as writing");

endmodule

`default_nettype wire

// File: project.f
design/core_pkg.sv
design/insn_decoder.sv
design/reg_file.sv
design/issue_stage.sv
design/alu.sv
design/writeback_stage.sv
design/exec_core.sv
sim/tb_exec_core.sv

// File: sim/tb_exec_core.sv
`default_nettype none

module tb_exec_core;

  localparam int clk_period   = 4;
  localparam int n_rand       = 16;
  localparam int n_chain      = 6;
  localparam int chain_len    = 12;
  // rough instruction count over all tests, doubled for the watchdog
  localparam int est_insns    = 96 + n_rand * 77 + n_chain * (chain_len + 6);
  localparam int limit_cycles = 2 * est_insns;
  localparam logic [4:0] subs [8] = '{core_pkg::sub_add, core_pkg::sub_sub,
    core_pkg::sub_and, core_pkg::sub_or, core_pkg::sub_xor, core_pkg::sub_srli,
    core_pkg::sub_slli, core_pkg::sub_rotri};

  logic              clk;
  logic              reset;
  logic              insn_valid;
  core_pkg::insn_u   insn;
  core_pkg::retire_t retire;

  logic [31:0]       shadow [32];
  logic [31:0]       rng = 32'd76;
  int                cycle = 0;
  int                errors = 0;
  int                errs_start = 0;
  int                tests_run = 0;
  int                tests_failed = 0;
  string             test_name = "reset";
  core_pkg::retire_t want_q [$];
  int                due_q [$];

  exec_core #(.reg_count(32)) UUT (
    .clk        (clk),
    .reset      (reset),
    .insn_valid (insn_valid),
    .insn       (insn),
    .retire     (retire)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic logic [31:0] r_word(input logic [4:0] sub, input logic [4:0] rt,
                                         input logic [4:0] ra, input logic [4:0] rb);
    return {1'b0, core_pkg::op_alu_1, rt, ra, rb, 5'b0, sub};
  endfunction

  function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rt,
                                         input logic [4:0] ra, input logic [14:0] imm);
    return {1'b0, op, rt, ra, imm};
  endfunction

  function automatic logic [31:0] movi_word(input logic [4:0] rt, input logic [19:0] imm);
    return {1'b0, core_pkg::op_movi, rt, imm};
  endfunction

  function automatic logic [31:0] chain_word(input int kind, input logic [4:0] rt,
                                             input logic [4:0] ra, input logic [4:0] rb);
    logic [31:0] w;
    case (kind)
      0: w = r_word(core_pkg::sub_add, rt, ra, rb);
      1: w = r_word(core_pkg::sub_sub, rt, ra, rb);
      2: w = r_word(core_pkg::sub_xor, rt, ra, rb);
      3: w = i_word(core_pkg::op_addi, rt, ra, 15'(next_rand()));
      4: w = r_word(core_pkg::sub_rotri, rt, ra, 5'(next_rand()));
      default: w = i_word(core_pkg::op_xori, rt, ra, 15'(next_rand()));
    endcase
    return w;
  endfunction

  // expected retirement from the raw word and the shadow registers
  function automatic core_pkg::retire_t predict(input logic [31:0] w, output logic writes);
    core_pkg::retire_t r;
    logic [31:0]       a;
    logic [31:0]       b;
    logic [4:0]        sh;
    logic              ovf_op;
    longint            wide;
    r = '0;
    r.valid = 1'b1;
    r.rd = w[24:20];
    a = shadow[w[19:15]];
    b = shadow[w[14:10]];
    sh = w[14:10];
    ovf_op = 1'b0;
    wide = 0;
    writes = 1'b1;
    case (w[30:25])
      core_pkg::op_alu_1: begin
        case (w[4:0])
          core_pkg::sub_add: r.data = a + b;
          core_pkg::sub_sub: begin
            r.data = a - b;
            wide = longint'($signed(a)) - longint'($signed(b));
            ovf_op = 1'b1;
          end
          core_pkg::sub_and: r.data = a & b;
          core_pkg::sub_or:  r.data = a | b;
          core_pkg::sub_xor: r.data = a ^ b;
          core_pkg::sub_srli: begin
            if (sh == 5'd0) writes = 1'b0;
            else r.data = a >> sh;
          end
          core_pkg::sub_slli:  r.data = a << sh;
          core_pkg::sub_rotri: r.data = (a >> sh) | (a << (6'd32 - 6'(sh)));
          default: r.illegal = 1'b1;
        endcase
      end
      core_pkg::op_addi: begin
        b = {{17{w[14]}}, w[14:0]};
        r.data = a + b;
        wide = longint'($signed(a)) + longint'($signed(b));
        ovf_op = 1'b1;
      end
      core_pkg::op_ori:  r.data = a | {17'b0, w[14:0]};
      core_pkg::op_xori: r.data = a ^ {17'b0, w[14:0]};
      core_pkg::op_movi: r.data = {{12{w[19]}}, w[19:0]};
      default: r.illegal = 1'b1;
    endcase
    if (r.illegal) writes = 1'b0;
    // true sum no longer fits in 32 signed bits
    if (ovf_op) r.overflow = (wide != longint'($signed(r.data)));
    if (!writes) begin
      r.data = '0;
      r.overflow = 1'b0;
    end
    return r;
  endfunction

  task automatic send(input logic [31:0] w);
    core_pkg::retire_t want;
    logic              writes;
    @(posedge clk);
    insn <= w;
    insn_valid <= 1'b1;
    want = predict(w, writes);
    if (writes) shadow[w[24:20]] = want.data;
    want_q.push_back(want);
    // sampled at the next edge, retired one edge later
    due_q.push_back(cycle + 3);
  endtask

  // full 32-bit value in three dependent steps
  task automatic load_reg(input logic [4:0] idx, input logic [31:0] value);
    send(movi_word(idx, value[31:12]));
    send(r_word(core_pkg::sub_slli, idx, idx, 5'd12));
    send(i_word(core_pkg::op_ori, idx, idx, {3'b0, value[11:0]}));
  endtask

  task automatic start_test(input string name);
    test_name = name;
    errs_start = errors;
  endtask

  task automatic finish_test();
    @(posedge clk);
    insn_valid <= 1'b0;
    while (want_q.size() != 0) @(posedge clk);
    tests_run++;
    if (errors == errs_start) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, errors - errs_start);
    end
  endtask

  always @(negedge clk) begin : compare
    core_pkg::retire_t want;
    int                due;
    if (!reset && retire.valid) begin
      spurious: assert (want_q.size() != 0) else begin
        $display("retirement in test %s with no instruction outstanding", test_name);
        errors++;
      end
      if (want_q.size() != 0) begin
        want = want_q.pop_front();
        due = due_q.pop_front();
        latency: assert (cycle == due) else begin
          $display("retirement in test %s at edge %0d, due at edge %0d", test_name, cycle, due);
          errors++;
        end
        illegal_ok: assert (retire.illegal == want.illegal) else begin
          $display("Fail %s illegal: expected %0b, actual %0b", test_name, want.illegal,
                   retire.illegal);
          errors++;
        end
        // decoder does not define rd for illegal words
        if (!want.illegal) begin
          rd_ok: assert (retire.rd == want.rd) else begin
            $display("Fail %s rd: expected %0d, actual %0d", test_name, want.rd, retire.rd);
            errors++;
          end
        end
        data_ok: assert (retire.data == want.data) else begin
          $display("Fail %s data: expected %h, actual %h", test_name, want.data, retire.data);
          errors++;
        end
        ovf_ok: assert (retire.overflow == want.overflow) else begin
          $display("Fail %s overflow: expected %0b, actual %0b", test_name, want.overflow,
                   retire.overflow);
          errors++;
        end
      end
    end
  end

  initial begin
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: tests still running after %0d cycles", limit_cycles);
    $display("TEST FAIL");
    $finish;
  end

  initial begin : main
    logic [4:0] ra;
    logic [4:0] rb;
    logic [4:0] rt;
    logic [4:0] prev;
    logic [4:0] prev2;
    insn = '0;
    insn_valid = 1'b0;
    reset = 1'b1;
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
    repeat (4) @(posedge clk);
    reset <= 1'b0;

    start_test("after_reset");
    repeat (8) begin
      @(negedge clk);
      idle_low: assert (!retire.valid) else begin
        $display("retire valid went high with no instruction sent");
        errors++;
      end
    end
    for (int i = 0; i < 32; i++) begin
      send(i_word(core_pkg::op_ori, 5'(i), 5'(i), 15'd0));
    end
    finish_test();

    start_test("reg_ops");
    for (int s = 0; s < 8; s++) begin
      repeat (n_rand) begin
        ra = 5'(next_rand());
        rb = 5'(next_rand());
        rt = 5'(next_rand());
        load_reg(ra, next_rand());
        load_reg(rb, next_rand());
        // rb doubles as the shift amount for shifts
        send(r_word(subs[s], rt, ra, rb));
      end
    end
    finish_test();

    start_test("imm_ops");
    repeat (n_rand) begin
      ra = 5'(next_rand());
      rt = 5'(next_rand());
      load_reg(ra, next_rand());
      send(i_word(core_pkg::op_addi, rt, ra, 15'(next_rand())));
      send(i_word(core_pkg::op_ori, rt, ra, 15'(next_rand())));
      send(i_word(core_pkg::op_xori, rt, ra, 15'(next_rand())));
      send(movi_word(rt, 20'(next_rand())));
    end
    load_reg(5'd1, 32'h7fff_ffff);
    load_reg(5'd2, 32'h8000_0000);
    send(i_word(core_pkg::op_addi, 5'd3, 5'd1, 15'd1));
    send(i_word(core_pkg::op_addi, 5'd4, 5'd2, 15'h7fff));
    send(r_word(core_pkg::sub_sub, 5'd5, 5'd2, 5'd1));
    send(r_word(core_pkg::sub_sub, 5'd6, 5'd1, 5'd2));
    send(r_word(core_pkg::sub_add, 5'd7, 5'd1, 5'd1));
    finish_test();

    start_test("chains");
    repeat (n_chain) begin
      prev = 5'(next_rand());
      prev2 = 5'(next_rand());
      load_reg(prev, next_rand());
      load_reg(prev2, next_rand());
      repeat (chain_len) begin
        rt = 5'(next_rand());
        send(chain_word(int'(next_rand() % 32'd6), rt, prev, prev2));
        prev2 = prev;
        prev = rt;
      end
    end
    finish_test();

    start_test("non_writing");
    repeat (n_rand) begin
      rt = 5'(next_rand());
      ra = 5'(next_rand());
      load_reg(rt, next_rand());
      send(r_word(core_pkg::sub_srli, rt, ra, 5'd0));
      send({1'b0, 6'b000111, rt, 20'(next_rand())});
      send(r_word(5'b11111, rt, ra, ra));
      // read back, the destination must be untouched
      send(i_word(core_pkg::op_ori, rt, rt, 15'd0));
    end
    finish_test();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
